//--- dv/matrix_quotient_tests.txt
# Header line m size_i size_j with decimal sizes
# Element line e a b skew with hex operands in row-major order
# Skew counts cycles from the A strobe to the B strobe and a negative skew sends B first
m 1 1
e 0064 0007 0
m 1 4
e 0003 0008 0
e ffff 0001 2
e 1234 0000 -1
e 0000 0005 3
m 2 3
e 0100 0010 0
e 00ff 00ff 1
e ffff ffff -2
e 8000 0003 0
e 0007 0002 4
e 0001 0000 -3
m 3 2
e 0009 0003 1
e 0002 0009 -1
e abcd 0001 0
e abcd 0000 5
e 0000 0000 -4
e 7fff 0002 2
m 3 3
e 0064 000a 0
e 0063 000a 1
e 0065 000a -1
e fffe ffff 0
e ffff 00ff 3
e 1000 0100 -5
e 0011 0011 2
e 0001 0002 0
e c350 00c8 -2
m 2 2
e 0000 0001 0
e 0002 0000 1
e 00ff 0010 -1
e 4321 0021 0

//--- dv/tb_matrix_quotient.sv
// Testbench for the matrix quotient accelerator
// Reads matrices from the tests file, drives operands with skew and gaps, checks every quotient

`timescale 1ns/1ps

module tb_matrix_quotient import mat_pkg::*; ();

  localparam int    DATA_SIZE  = DATA_W;
  // Longest idle gap between elements, in cycles
  localparam int    MAX_GAP    = 3;
  localparam string TESTS_FILE = "dv/matrix_quotient_tests.txt";

  logic              CLK;
  logic              RST;
  logic              START;
  logic              READY;
  logic [DIM_W-1:0]  SIZE_I;
  logic [DIM_W-1:0]  SIZE_J;
  logic [DATA_W-1:0] DATA_A_IN;
  logic              DATA_A_ENABLE;
  logic [DATA_W-1:0] DATA_B_IN;
  logic              DATA_B_ENABLE;
  logic [DATA_W-1:0] DATA_OUT;
  logic              DATA_OUT_SCALAR_ENABLE;
  logic              DATA_OUT_VECTOR_ENABLE;
  logic              DATA_OUT_MATRIX_ENABLE;

  // Tests file contents, one entry per matrix and per element
  int                mat_si[$];
  int                mat_sj[$];
  logic [DATA_W-1:0] el_a[$];
  logic [DATA_W-1:0] el_b[$];
  int                el_skew[$];
  int                max_skew;

  int                errors;
  int                cycle_cnt;
  int                cycle_limit;
  bit                load_ok;

  // Output pulse counters
  int                scalar_cnt;
  int                vector_cnt;
  int                matrix_cnt;
  int                ready_cnt;

  matrix_quotient_top #(
    .DATA_SIZE (DATA_SIZE)
  ) i_dut (
    .CLK                    (CLK),
    .RST                    (RST),
    .START                  (START),
    .READY                  (READY),
    .SIZE_I                 (SIZE_I),
    .SIZE_J                 (SIZE_J),
    .DATA_A_IN              (DATA_A_IN),
    .DATA_A_ENABLE          (DATA_A_ENABLE),
    .DATA_B_IN              (DATA_B_IN),
    .DATA_B_ENABLE          (DATA_B_ENABLE),
    .DATA_OUT               (DATA_OUT),
    .DATA_OUT_SCALAR_ENABLE (DATA_OUT_SCALAR_ENABLE),
    .DATA_OUT_VECTOR_ENABLE (DATA_OUT_VECTOR_ENABLE),
    .DATA_OUT_MATRIX_ENABLE (DATA_OUT_MATRIX_ENABLE)
  );

  // 100 ns clock
  always #50 CLK = ~CLK;

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and timeout
  ////////////////////////////////////////////////////////////////////////////

  // Outputs sampled mid cycle
  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_SCALAR_ENABLE) scalar_cnt = scalar_cnt + 1;
      if (DATA_OUT_VECTOR_ENABLE) vector_cnt = vector_cnt + 1;
      if (DATA_OUT_MATRIX_ENABLE) matrix_cnt = matrix_cnt + 1;
      if (READY) ready_cnt = ready_cnt + 1;
    end
  end

  initial begin
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge CLK);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout after %0d cycles, the DUT stopped producing results", cycle_cnt);
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Header lines start with m, element lines with e, anything else is skipped
  function automatic bit load_tests();
    int                fd;
    int                n;
    int                si;
    int                sj;
    int                skew;
    int                total;
    byte               tag;
    string             line;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the tests file %s", TESTS_FILE);
      return 0;
    end
    total    = 0;
    max_skew = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 0) begin
        tag = line.getc(0);
        if (tag == "m") begin
          n = $sscanf(line, "m %d %d", si, sj);
          if (n != 2 || si < 1 || sj < 1) begin
            $display("Bad matrix header in the tests file: %s", line);
            $fclose(fd);
            return 0;
          end
          mat_si.push_back(si);
          mat_sj.push_back(sj);
          total = total + si * sj;
        end else if (tag == "e") begin
          n = $sscanf(line, "e %h %h %d", a, b, skew);
          if (n != 3) begin
            $display("Bad element line in the tests file: %s", line);
            $fclose(fd);
            return 0;
          end
          el_a.push_back(a);
          el_b.push_back(b);
          el_skew.push_back(skew);
          if (skew > max_skew) max_skew = skew;
          if (-skew > max_skew) max_skew = -skew;
        end
      end
    end
    $fclose(fd);
    if (mat_si.size() == 0 || total != el_a.size()) begin
      $display("Tests file holds %0d elements where its headers need %0d", el_a.size(), total);
      return 0;
    end
    return 1;
  endfunction

  // Unsigned quotient, zero divisor saturates
  function automatic logic [DATA_W-1:0] expected_quotient(input logic [DATA_W-1:0] a,
                                                          input logic [DATA_W-1:0] b);
    if (b == '0) return '1;
    return a / b;
  endfunction

  task automatic strobe_a(input logic [DATA_W-1:0] v);
    DATA_A_IN     = v;
    DATA_A_ENABLE = 1'b1;
    @(negedge CLK);
    DATA_A_ENABLE = 1'b0;
  endtask

  task automatic strobe_b(input logic [DATA_W-1:0] v);
    DATA_B_IN     = v;
    DATA_B_ENABLE = 1'b1;
    @(negedge CLK);
    DATA_B_ENABLE = 1'b0;
  endtask

  // Positive skew delays B after A, negative sends B first
  task automatic send_element(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                              input int skew);
    if (skew == 0) begin
      DATA_A_IN     = a;
      DATA_B_IN     = b;
      DATA_A_ENABLE = 1'b1;
      DATA_B_ENABLE = 1'b1;
      @(negedge CLK);
      DATA_A_ENABLE = 1'b0;
      DATA_B_ENABLE = 1'b0;
    end else if (skew > 0) begin
      strobe_a(a);
      repeat (skew - 1) @(negedge CLK);
      strobe_b(b);
    end else begin
      strobe_b(b);
      repeat (-skew - 1) @(negedge CLK);
      strobe_a(a);
    end
  endtask

  task automatic start_matrix(input int si, input int sj);
    SIZE_I = DIM_W'(si);
    SIZE_J = DIM_W'(sj);
    START  = 1'b1;
    @(negedge CLK);
    START  = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_matrices();
    int                idx;
    int                m;
    int                r;
    int                c;
    int                gap;
    int                snap_s;
    int                snap_v;
    int                snap_m;
    int                snap_r;
    logic [DATA_W-1:0] exp_q;
    logic              row_end;
    logic              mat_end;
    idx = 0;
    for (m = 0; m < mat_si.size(); m++) begin
      start_matrix(mat_si[m], mat_sj[m]);
      snap_s = scalar_cnt;
      snap_v = vector_cnt;
      snap_m = matrix_cnt;
      snap_r = ready_cnt;
      for (r = 0; r < mat_si[m]; r++) begin
        for (c = 0; c < mat_sj[m]; c++) begin
          gap = $urandom % (MAX_GAP + 1);
          repeat (gap) @(negedge CLK);
          send_element(el_a[idx], el_b[idx], el_skew[idx]);
          // Next element only after this one is out
          while (DATA_OUT_SCALAR_ENABLE !== 1'b1) @(negedge CLK);
          exp_q   = expected_quotient(el_a[idx], el_b[idx]);
          row_end = (c == mat_sj[m] - 1);
          mat_end = row_end && (r == mat_si[m] - 1);
          if (DATA_OUT !== exp_q) begin
            $display("** Error at %0t ns: matrix %0d element %0d/%0d DATA_OUT %h expected %h",
                     $time, m, r, c, DATA_OUT, exp_q);
            errors = errors + 1;
          end
          if (DATA_OUT_VECTOR_ENABLE !== row_end) begin
            $display("** Error at %0t ns: matrix %0d element %0d/%0d vector enable %b expected %b",
                     $time, m, r, c, DATA_OUT_VECTOR_ENABLE, row_end);
            errors = errors + 1;
          end
          if (DATA_OUT_MATRIX_ENABLE !== mat_end || READY !== mat_end) begin
            $display("** Error at %0t ns: matrix %0d element %0d/%0d matrix enable %b READY %b",
                     $time, m, r, c, DATA_OUT_MATRIX_ENABLE, READY);
            errors = errors + 1;
          end
          idx = idx + 1;
        end
      end
      // Let the monitor settle before comparing pulse counts
      @(negedge CLK);
      if (scalar_cnt - snap_s != mat_si[m] * mat_sj[m] || vector_cnt - snap_v != mat_si[m]
          || matrix_cnt - snap_m != 1 || ready_cnt - snap_r != 1) begin
        $display("** Error at %0t ns: matrix %0d counts scalar %0d vector %0d matrix %0d ready %0d",
                 $time, m, scalar_cnt - snap_s, vector_cnt - snap_v, matrix_cnt - snap_m,
                 ready_cnt - snap_r);
        errors = errors + 1;
      end
    end
  endtask

  initial begin
    CLK           = 1'b0;
    RST           = 1'b1;
    START         = 1'b0;
    SIZE_I        = '0;
    SIZE_J        = '0;
    DATA_A_IN     = '0;
    DATA_A_ENABLE = 1'b0;
    DATA_B_IN     = '0;
    DATA_B_ENABLE = 1'b0;
    errors        = 0;
    cycle_cnt     = 0;
    cycle_limit   = 0;
    scalar_cnt    = 0;
    vector_cnt    = 0;
    matrix_cnt    = 0;
    ready_cnt     = 0;
    void'($urandom(32'h21ee));
    load_ok = load_tests();
    if (!load_ok) begin
      $display("=== FAIL ===");
      $finish;
    end else begin
      cycle_limit = 20 + 4 * mat_si.size()
                    + el_a.size() * (DATA_SIZE + 3 + MAX_GAP + max_skew + 2);
      repeat (5) @(negedge CLK);
      RST = 1'b0;
      @(negedge CLK);
      // Idle outputs straight after reset
      if (DATA_OUT !== '0 || DATA_OUT_SCALAR_ENABLE !== 1'b0 || DATA_OUT_VECTOR_ENABLE !== 1'b0
          || DATA_OUT_MATRIX_ENABLE !== 1'b0 || READY !== 1'b0) begin
        $display("** Error at %0t ns: outputs not idle after reset, DATA_OUT %h", $time, DATA_OUT);
        errors = errors + 1;
      end
      run_matrices();
      $display("Closing: %0d errors over %0d elements in %0d matrices", errors, el_a.size(),
               mat_si.size());
      if (errors == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the matrix quotient testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_matrix_quotient \
  -f src.f -o sim_matrix_quotient

# Pass or fail comes from the printed result, not the exit status
output=$(./obj_dir/sim_matrix_quotient || true)
echo "$output"

if echo "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1

//--- src.f
src/mat_pkg.sv
src/elem_capture.sv
src/restoring_divider.sv
src/result_emitter.sv
src/matrix_quotient_top.sv
dv/tb_matrix_quotient.sv

//--- src/elem_capture.sv
// Input side of the quotient accelerator
// Collects A and B operands, tracks row and column, launches divisions

`timescale 1ns/1ps

module elem_capture import mat_pkg::*; (
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  logic [DIM_W-1:0] size_i,
  input  logic [DIM_W-1:0] size_j,
  input  logic [DATA_W-1:0] data_a,
  input  logic             data_a_enable,
  input  logic [DATA_W-1:0] data_b,
  input  logic             data_b_enable,
  input  logic             div_done,
  output logic             div_start,
  output operand_pair_t    div_operands,
  output elem_pos_t        div_pos
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Matrix accepted, strobes taken
  logic              armed;
  // Division in flight
  logic              busy;

  logic              have_a;
  logic              have_b;
  logic [DATA_W-1:0] a_reg;
  logic [DATA_W-1:0] b_reg;

  logic [DIM_W-1:0]  row_cnt;
  logic [DIM_W-1:0]  col_cnt;

  logic              a_take;
  logic              b_take;
  logic              launch;
  logic              row_last;
  logic              mat_last;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe qualification
  ////////////////////////////////////////////////////////////////////////////

  // Drop strobes before START and while dividing
  assign a_take = data_a_enable & armed & ~busy;
  assign b_take = data_b_enable & armed & ~busy;

  // Second operand seen this cycle, or both already held
  assign launch = (have_a | a_take) & (have_b | b_take) & ~start;

  assign row_last = (col_cnt == size_j - DIM_W'(1));
  assign mat_last = row_last & (row_cnt == size_i - DIM_W'(1));

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      armed     <= 1'b0;
      busy      <= 1'b0;
      have_a    <= 1'b0;
      have_b    <= 1'b0;
      row_cnt   <= '0;
      col_cnt   <= '0;
      div_start <= 1'b0;
    end else begin
      div_start <= launch;
      if (start) begin
        // New matrix, counting restarts from row 0
        armed   <= 1'b1;
        have_a  <= 1'b0;
        have_b  <= 1'b0;
        row_cnt <= '0;
        col_cnt <= '0;
      end else if (launch) begin
        have_a <= 1'b0;
        have_b <= 1'b0;
        busy   <= 1'b1;
        if (mat_last) begin
          armed   <= 1'b0;
          row_cnt <= '0;
          col_cnt <= '0;
        end else if (row_last) begin
          row_cnt <= row_cnt + DIM_W'(1);
          col_cnt <= '0;
        end else begin
          col_cnt <= col_cnt + DIM_W'(1);
        end
      end else begin
        if (a_take) have_a <= 1'b1;
        if (b_take) have_b <= 1'b1;
      end
      if (div_done) busy <= 1'b0;
    end
  end

  // Operand holding and handover
  always_ff @(posedge CLK) begin
    if (a_take) a_reg <= data_a;
    if (b_take) b_reg <= data_b;
    if (launch) begin
      // Bypass the holding register for the strobe that completes the pair
      div_operands.dividend <= a_take ? data_a : a_reg;
      div_operands.divisor  <= b_take ? data_b : b_reg;
      div_pos.row_last      <= row_last;
      div_pos.mat_last      <= mat_last;
    end
  end

  // Source must wait for the scalar enable before the next element
  a_no_strobe_busy : assert property (@(posedge CLK) disable iff (RST)
    busy |-> !(data_a_enable || data_b_enable));

endmodule

//--- src/mat_pkg.sv
// Shared widths and payload types of the matrix quotient accelerator
// Operand pair, element position and quotient result structs

package mat_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Default operand width, top level DATA_SIZE matches it
  localparam int DATA_W = 16;

  // Size inputs and row/column counters
  localparam int DIM_W = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Payload types
  ////////////////////////////////////////////////////////////////////////////

  // Both operands of one element, handed to the divider together
  typedef struct packed {
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
  } operand_pair_t;

  // Where the element in flight sits in the matrix
  typedef struct packed {
    // Last column of its row
    logic row_last;
    // Last element of the whole matrix
    logic mat_last;
  } elem_pos_t;

  // Divider output
  typedef struct packed {
    logic [DATA_W-1:0] quotient;
    // Divisor was zero, quotient forced to all ones
    logic              div_by_zero;
  } quot_result_t;

endpackage

//--- src/matrix_quotient_top.sv
// Top level of the streaming matrix element-wise quotient accelerator
// Capture, divider and emitter blocks wired in a chain

`timescale 1ns/1ps

module matrix_quotient_top import mat_pkg::*; #(
  parameter int DATA_SIZE = DATA_W
) (
  input  logic              CLK,
  input  logic              RST,

  // Control
  input  logic              START,
  output logic              READY,

  // Matrix size, stable during a matrix
  input  logic [DIM_W-1:0]  SIZE_I,
  input  logic [DIM_W-1:0]  SIZE_J,

  // Operands
  input  logic [DATA_W-1:0] DATA_A_IN,
  input  logic              DATA_A_ENABLE,
  input  logic [DATA_W-1:0] DATA_B_IN,
  input  logic              DATA_B_ENABLE,

  // Results
  output logic [DATA_W-1:0] DATA_OUT,
  output logic              DATA_OUT_SCALAR_ENABLE,
  output logic              DATA_OUT_VECTOR_ENABLE,
  output logic              DATA_OUT_MATRIX_ENABLE
);

  // Payload structs are sized by the package width
  initial begin
    a_size_match : assert (DATA_SIZE == DATA_W)
      else $fatal(1, "DATA_SIZE %0d differs from DATA_W %0d", DATA_SIZE, DATA_W);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////////////////////

  logic          div_start;
  operand_pair_t div_operands;
  elem_pos_t     div_pos;
  logic          div_done;
  quot_result_t  div_result;
  elem_pos_t     done_pos;

  elem_capture u_capture (
    .CLK           (CLK),
    .RST           (RST),
    .start         (START),
    .size_i        (SIZE_I),
    .size_j        (SIZE_J),
    .data_a        (DATA_A_IN),
    .data_a_enable (DATA_A_ENABLE),
    .data_b        (DATA_B_IN),
    .data_b_enable (DATA_B_ENABLE),
    .div_done      (div_done),
    .div_start     (div_start),
    .div_operands  (div_operands),
    .div_pos       (div_pos)
  );

  restoring_divider #(
    .DATA_SIZE (DATA_SIZE)
  ) u_divider (
    .CLK          (CLK),
    .RST          (RST),
    .div_start    (div_start),
    .div_operands (div_operands),
    .div_pos      (div_pos),
    .div_done     (div_done),
    .div_result   (div_result),
    .done_pos     (done_pos)
  );

  result_emitter u_emitter (
    .CLK                    (CLK),
    .RST                    (RST),
    .div_done               (div_done),
    .div_result             (div_result),
    .done_pos               (done_pos),
    .data_out               (DATA_OUT),
    .data_out_scalar_enable (DATA_OUT_SCALAR_ENABLE),
    .data_out_vector_enable (DATA_OUT_VECTOR_ENABLE),
    .data_out_matrix_enable (DATA_OUT_MATRIX_ENABLE),
    .ready                  (READY)
  );

endmodule

//--- src/restoring_divider.sv
// Bit-serial unsigned restoring divider
// One quotient bit per cycle, zero divisor gives all ones

`timescale 1ns/1ps

module restoring_divider import mat_pkg::*; #(
  parameter int DATA_SIZE = DATA_W
) (
  input  logic          CLK,
  input  logic          RST,
  input  logic          div_start,
  input  operand_pair_t div_operands,
  input  elem_pos_t     div_pos,
  output logic          div_done,
  output quot_result_t  div_result,
  output elem_pos_t     done_pos
);

  localparam int CNT_W = $clog2(DATA_SIZE + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  logic              running;
  logic [CNT_W-1:0]  iter_cnt;
  logic              last_iter;

  // Partial remainder
  logic [DATA_W-1:0] rem;
  // Dividend shifts out on the left, quotient bits fill in on the right
  logic [DATA_W-1:0] dq;
  logic [DATA_W-1:0] divisor;
  logic              zero_div;

  logic [DATA_W:0]   trial;
  logic              q_bit;
  logic [DATA_W-1:0] rem_next;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  // Shift in next dividend bit, try the subtraction
  assign trial = {rem, dq[DATA_W-1]} - {1'b0, divisor};
  // No borrow means the divisor fits
  assign q_bit = ~trial[DATA_W];
  // Restore on borrow
  assign rem_next = q_bit ? trial[DATA_W-1:0] : {rem[DATA_W-2:0], dq[DATA_W-1]};

  assign last_iter = (iter_cnt == CNT_W'(DATA_SIZE - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Iteration control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running  <= 1'b0;
      iter_cnt <= '0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        running  <= 1'b1;
        iter_cnt <= '0;
      end else if (running) begin
        iter_cnt <= iter_cnt + CNT_W'(1);
        if (last_iter) begin
          running  <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (div_start) begin
      rem      <= '0;
      dq       <= div_operands.dividend;
      divisor  <= div_operands.divisor;
      zero_div <= (div_operands.divisor == '0);
      // Position rides along untouched
      done_pos <= div_pos;
    end else if (running) begin
      rem <= rem_next;
      dq  <= {dq[DATA_W-2:0], q_bit};
      if (last_iter) begin
        div_result.quotient    <= zero_div ? '1 : {dq[DATA_W-2:0], q_bit};
        div_result.div_by_zero <= zero_div;
      end
    end
  end

  // Capture side holds off while busy, so no restart mid division
  a_no_start_running : assert property (@(posedge CLK) disable iff (RST)
    running |-> !div_start);

endmodule

//--- src/result_emitter.sv
// Output side of the quotient accelerator
// Registers the quotient, makes scalar, vector and matrix enables and READY

`timescale 1ns/1ps

module result_emitter import mat_pkg::*; (
  input  logic              CLK,
  input  logic              RST,
  input  logic              div_done,
  input  quot_result_t      div_result,
  input  elem_pos_t         done_pos,
  output logic [DATA_W-1:0] data_out,
  output logic              data_out_scalar_enable,
  output logic              data_out_vector_enable,
  output logic              data_out_matrix_enable,
  output logic              ready
);

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      data_out               <= '0;
      data_out_scalar_enable <= 1'b0;
      data_out_vector_enable <= 1'b0;
      data_out_matrix_enable <= 1'b0;
      ready                  <= 1'b0;
    end else begin
      // One cycle pulses, low again unless another done arrives
      data_out_scalar_enable <= div_done;
      data_out_vector_enable <= div_done & done_pos.row_last;
      data_out_matrix_enable <= div_done & done_pos.mat_last;
      ready                  <= div_done & done_pos.mat_last;

      // Quotient held until the next element
      if (div_done) begin
        data_out <= div_result.div_by_zero ? '1 : div_result.quotient;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  // Last element of a matrix also closes its row
  a_matrix_has_vector : assert property (@(posedge CLK) disable iff (RST)
    data_out_matrix_enable |-> data_out_vector_enable);

  // Division takes several cycles, so enables never come back to back
  a_scalar_single : assert property (@(posedge CLK) disable iff (RST)
    data_out_scalar_enable |=> !data_out_scalar_enable);

endmodule
